// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary -Wno-fatal
TOP      = opl_ctrl_tb
FILELIST = filelist.f
SIM      = obj_dir/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "Testbench passed"

clean:
	rm -rf obj_dir

// ==== design/opl_bus_decode.sv ====
/* Bus decode that turns BAR chip selects and address into a responder select,
   merges the responder answers and answers unmapped accesses with an error */

`timescale 1ns/1ps

module opl_bus_decode
  import opl_bus_pkg::*;
(
  input  logic                               Bus2IP_Clk,
  input  logic                               S_AXI_ARESETN,
  input  logic [1:0]                         cs,
  input  bus_req_t                           req,
  input  bus_rsp_t [NUM_RESPONDERS-1:0]      rsp,
  output logic [NUM_RESPONDERS-1:0]          sel,
  output bus_rsp_t                           rsp_out
);

  bar0_idx_t idx;
  tbl_win_t  win;
  logic      unmapped;
  logic      err_rd_q;
  logic      err_wr_q;
  bus_rsp_t  merged;

  assign idx = req.addr[6:2];
  assign win = req.addr[31:6];

  // CS[1] selects BAR0 and CS[0] selects BAR1
  always_comb begin
    sel              = '0;
    sel[RESP_REGS]   = cs[1] && (idx < BAR0_NUM_REGS);
    sel[RESP_LPM]    = cs[0] && (win == TBL_WIN_LPM);
    sel[RESP_ARP]    = cs[0] && (win == TBL_WIN_ARP);
    sel[RESP_FILTER] = cs[0] && (win == TBL_WIN_FILTER);
  end

  assign unmapped = (cs[1] && (idx >= BAR0_NUM_REGS)) ||
                    (cs[0] && (win > TBL_WIN_FILTER));

  // First error stage lines up with the registered responder answers
  always_ff @(posedge Bus2IP_Clk) begin
    if (!S_AXI_ARESETN) begin
      err_rd_q <= 1'b0;
      err_wr_q <= 1'b0;
    end else begin
      err_rd_q <= unmapped && req.rnw;
      err_wr_q <= unmapped && !req.rnw;
    end
  end

  // Only one responder acks per access
  always_comb begin
    merged = '0;
    for (int i = 0; i < NUM_RESPONDERS; i++) begin
      merged.rd_ack |= rsp[i].rd_ack;
      merged.wr_ack |= rsp[i].wr_ack;
      merged.error  |= rsp[i].error;
      if (rsp[i].rd_ack) begin
        merged.data |= rsp[i].data;
      end
    end
    merged.rd_ack |= err_rd_q;
    merged.wr_ack |= err_wr_q;
    merged.error  |= err_rd_q | err_wr_q;
  end

  always_ff @(posedge Bus2IP_Clk) begin
    if (!S_AXI_ARESETN) begin
      rsp_out <= '0;
    end else begin
      rsp_out <= merged;
    end
  end

endmodule

// ==== design/opl_bus_pkg.sv ====
/* Register bus package for the output port lookup control block
   Bus word and request/response types, BAR0 map and table window layout */

package opl_bus_pkg;

  typedef logic [31:0] bus_word_t;
  typedef logic [31:0] bus_addr_t;
  typedef logic [3:0]  bus_be_t;

  // Address fields
  typedef logic [4:0]  bar0_idx_t;
  typedef logic [3:0]  tbl_ofs_t;
  typedef logic [25:0] tbl_win_t;
  typedef logic [3:0]  tbl_row_t;

  typedef struct packed {
    bus_addr_t addr;
    logic      rnw;
    bus_word_t data;
    bus_be_t   be;
  } bus_req_t;

  typedef struct packed {
    bus_word_t data;
    logic      rd_ack;
    logic      wr_ack;
    logic      error;
  } bus_rsp_t;

  // Responder slots in the select vector
  localparam int NUM_RESPONDERS = 4;
  localparam int RESP_REGS      = 0;
  localparam int RESP_LPM       = 1;
  localparam int RESP_ARP       = 2;
  localparam int RESP_FILTER    = 3;

  // BAR0 word indexes
  localparam int BAR0_NUM_REGS     = 19;
  localparam int REG_CTRL_IDX      = 0;
  localparam int REG_MAC_BASE_IDX  = 1;
  localparam int REG_NUM_MAC_WORDS = 8;
  localparam int REG_CNTR_BASE_IDX = 9;
  localparam bus_word_t MAC_HI_MASK = 32'h0000_ffff;

  // BAR1 table windows
  localparam int TBL_CMD_WRITE_OFS = 8;
  localparam int TBL_CMD_READ_OFS  = 9;
  localparam int TBL_WIN_LPM       = 0;
  localparam int TBL_WIN_ARP       = 1;
  localparam int TBL_WIN_FILTER    = 2;
  localparam int LPM_NUM_COLS      = 4;
  localparam int ARP_NUM_COLS      = 3;
  localparam int FILTER_NUM_COLS   = 1;

  // Byte-enable merge of a write into a stored word
  function automatic bus_word_t be_merge(bus_word_t old_word, bus_word_t new_word,
                                         bus_be_t be);
    bus_word_t result;
    for (int b = 0; b < 4; b++) begin
      result[8*b +: 8] = be[b] ? new_word[8*b +: 8] : old_word[8*b +: 8];
    end
    return result;
  endfunction

endpackage

// ==== design/opl_ctrl_top.sv ====
/* Output port lookup control top with the register bus decode, BAR0 register
   bank, statistics counters and the LPM, ARP and destination IP filter tables */

`timescale 1ns/1ps

module opl_ctrl_top
  import opl_bus_pkg::*;
  import opl_router_pkg::*;
#(
  parameter int LPM_LUT_DEPTH = 16,
  parameter int ARP_LUT_DEPTH = 16,
  parameter int FILTER_DEPTH  = 16
) (
  input  logic                              Bus2IP_Clk,
  input  logic                              S_AXI_ARESETN,
  input  logic [1:0]                        Bus2IP_CS,
  input  bus_addr_t                         Bus2IP_Addr,
  input  logic                              Bus2IP_RNW,
  input  bus_word_t                         Bus2IP_Data,
  input  bus_be_t                           Bus2IP_BE,
  output bus_word_t                         IP2Bus_Data,
  output logic                              IP2Bus_RdAck,
  output logic                              IP2Bus_WrAck,
  output logic                              IP2Bus_Error,
  input  stat_events_t                      events,
  output mac_set_t                          macs,
  input  tbl_row_t                          lpm_lookup_addr,
  output bus_word_t [LPM_NUM_COLS-1:0]      lpm_row,
  input  tbl_row_t                          arp_lookup_addr,
  output bus_word_t [ARP_NUM_COLS-1:0]      arp_row,
  input  tbl_row_t                          filter_lookup_addr,
  output bus_word_t [FILTER_NUM_COLS-1:0]   filter_row
);

  bus_req_t                      req;
  bus_rsp_t                      rsp_out;
  bus_rsp_t [NUM_RESPONDERS-1:0] rsp;
  logic [NUM_RESPONDERS-1:0]     sel;
  stat_counts_t                  counts;
  logic                          rst_cntrs;

  assign req.addr = Bus2IP_Addr;
  assign req.rnw  = Bus2IP_RNW;
  assign req.data = Bus2IP_Data;
  assign req.be   = Bus2IP_BE;

  assign IP2Bus_Data  = rsp_out.data;
  assign IP2Bus_RdAck = rsp_out.rd_ack;
  assign IP2Bus_WrAck = rsp_out.wr_ack;
  assign IP2Bus_Error = rsp_out.error;

  opl_bus_decode i_opl_bus_decode (
    .Bus2IP_Clk, .S_AXI_ARESETN,
    .cs(Bus2IP_CS), .req, .rsp, .sel, .rsp_out
  );

  opl_reg_bank i_opl_reg_bank (
    .Bus2IP_Clk, .S_AXI_ARESETN,
    .sel(sel[RESP_REGS]), .req, .counts,
    .rsp(rsp[RESP_REGS]), .macs, .rst_cntrs
  );

  opl_stat_counters i_opl_stat_counters (
    .Bus2IP_Clk, .S_AXI_ARESETN,
    .events, .clear(rst_cntrs), .counts
  );

  opl_table_regs #(.TBL_NUM_COLS(LPM_NUM_COLS), .TBL_NUM_ROWS(LPM_LUT_DEPTH)) i_lpm_table (
    .Bus2IP_Clk, .S_AXI_ARESETN,
    .sel(sel[RESP_LPM]), .req, .lookup_addr(lpm_lookup_addr),
    .rsp(rsp[RESP_LPM]), .lookup_row(lpm_row)
  );

  opl_table_regs #(.TBL_NUM_COLS(ARP_NUM_COLS), .TBL_NUM_ROWS(ARP_LUT_DEPTH)) i_arp_table (
    .Bus2IP_Clk, .S_AXI_ARESETN,
    .sel(sel[RESP_ARP]), .req, .lookup_addr(arp_lookup_addr),
    .rsp(rsp[RESP_ARP]), .lookup_row(arp_row)
  );

  opl_table_regs #(
    .TBL_NUM_COLS(FILTER_NUM_COLS),
    .TBL_NUM_ROWS(FILTER_DEPTH)
  ) i_filter_table (
    .Bus2IP_Clk, .S_AXI_ARESETN,
    .sel(sel[RESP_FILTER]), .req, .lookup_addr(filter_lookup_addr),
    .rsp(rsp[RESP_FILTER]), .lookup_row(filter_row)
  );

endmodule

// ==== design/opl_reg_bank.sv ====
/* BAR0 register bank with the counter clear control, the port MAC addresses
   and readback of the packet statistics counters */

`timescale 1ns/1ps

module opl_reg_bank
  import opl_bus_pkg::*;
  import opl_router_pkg::*;
(
  input  logic         Bus2IP_Clk,
  input  logic         S_AXI_ARESETN,
  input  logic         sel,
  input  bus_req_t     req,
  input  stat_counts_t counts,
  output bus_rsp_t     rsp,
  output mac_set_t     macs,
  output logic         rst_cntrs
);

  bar0_idx_t idx;
  logic      wr_en;
  logic      rd_en;
  logic      rst_cntrs_q;
  bus_word_t rd_data;
  bus_word_t mac_q [REG_NUM_MAC_WORDS];

  assign idx   = req.addr[6:2];
  assign wr_en = sel && !req.rnw;
  assign rd_en = sel && req.rnw;

  // Even words hold MAC bits 31:0 and odd words bits 47:32
  always_ff @(posedge Bus2IP_Clk) begin
    if (!S_AXI_ARESETN) begin
      rst_cntrs_q <= 1'b0;
      for (int m = 0; m < REG_NUM_MAC_WORDS; m++) begin
        mac_q[m] <= '0;
      end
    end else if (wr_en) begin
      if (idx == REG_CTRL_IDX && req.be[0]) begin
        rst_cntrs_q <= req.data[0];
      end
      for (int m = 0; m < REG_NUM_MAC_WORDS; m++) begin
        if (idx == REG_MAC_BASE_IDX + m) begin
          mac_q[m] <= be_merge(mac_q[m], req.data, req.be) &
                      ((m % 2 == 1) ? MAC_HI_MASK : '1);
        end
      end
    end
  end

  // Read mux with the counters in package order
  always_comb begin
    rd_data = '0;
    if (idx == REG_CTRL_IDX) begin
      rd_data[0] = rst_cntrs_q;
    end
    for (int m = 0; m < REG_NUM_MAC_WORDS; m++) begin
      if (idx == REG_MAC_BASE_IDX + m) begin
        rd_data = mac_q[m];
      end
    end
    for (int c = 0; c < NUM_STAT_CNTRS; c++) begin
      if (idx == REG_CNTR_BASE_IDX + c) begin
        rd_data = counts[c];
      end
    end
  end

  always_ff @(posedge Bus2IP_Clk) begin
    if (!S_AXI_ARESETN) begin
      rsp <= '0;
    end else begin
      rsp.data   <= rd_data;
      rsp.rd_ack <= rd_en;
      rsp.wr_ack <= wr_en;
      rsp.error  <= 1'b0;
    end
  end

  assign rst_cntrs  = rst_cntrs_q;
  assign macs.mac_0 = {mac_q[1][MAC_HI_BITS-1:0], mac_q[0]};
  assign macs.mac_1 = {mac_q[3][MAC_HI_BITS-1:0], mac_q[2]};
  assign macs.mac_2 = {mac_q[5][MAC_HI_BITS-1:0], mac_q[4]};
  assign macs.mac_3 = {mac_q[7][MAC_HI_BITS-1:0], mac_q[6]};

endmodule

// ==== design/opl_router_pkg.sv ====
/* Router side package with network field types, the statistics event
   pulses and counter array, and the port MAC address set */

package opl_router_pkg;

  import opl_bus_pkg::*;

  typedef logic [47:0] mac_addr_t;
  typedef logic [31:0] ipv4_addr_t;

  // Upper MAC word carries only 16 bits
  localparam int MAC_HI_BITS = 16;

  typedef struct packed {
    mac_addr_t mac_0;
    mac_addr_t mac_1;
    mac_addr_t mac_2;
    mac_addr_t mac_3;
  } mac_set_t;

  localparam int NUM_STAT_CNTRS = 10;

  // Field order follows the counter order and puts from_cpu in the top bit
  typedef struct packed {
    logic from_cpu;
    logic options_ver;
    logic bad_ttl;
    logic dest_ip_hit;
    logic forwarded;
    logic dropped_checksum;
    logic non_ip;
    logic arp_miss;
    logic lpm_miss;
    logic dropped_wrong_dst_mac;
  } stat_events_t;

  // Element 0 is the from_cpu counter
  typedef bus_word_t [0:NUM_STAT_CNTRS-1] stat_counts_t;

  // Bit of the flattened event vector that drives counter i
  function automatic int stat_event_bit(int i);
    return NUM_STAT_CNTRS - 1 - i;
  endfunction

endpackage

// ==== design/opl_stat_counters.sv ====
/* Packet statistics with ten wrapping 32-bit counters, one per datapath
   event pulse, held at zero while the clear level is set */

`timescale 1ns/1ps

module opl_stat_counters
  import opl_router_pkg::*;
(
  input  logic         Bus2IP_Clk,
  input  logic         S_AXI_ARESETN,
  input  stat_events_t events,
  input  logic         clear,
  output stat_counts_t counts
);

  logic [NUM_STAT_CNTRS-1:0] ev_vec;

  // Flattened pulses with from_cpu in the top bit
  assign ev_vec = events;

  always_ff @(posedge Bus2IP_Clk) begin
    if (!S_AXI_ARESETN || clear) begin
      counts <= '0;
    end else begin
      for (int i = 0; i < NUM_STAT_CNTRS; i++) begin
        // Wraps at 2^32
        if (ev_vec[stat_event_bit(i)]) begin
          counts[i] <= counts[i] + 1'b1;
        end
      end
    end
  end

endmodule

// ==== design/opl_table_regs.sv ====
/* Table window with staging words and row write/read commands over BAR1,
   and a registered lookup read port for the datapath */

`timescale 1ns/1ps

module opl_table_regs
  import opl_bus_pkg::*;
#(
  parameter int TBL_NUM_COLS = 4,
  parameter int TBL_NUM_ROWS = 16
) (
  input  logic                          Bus2IP_Clk,
  input  logic                          S_AXI_ARESETN,
  input  logic                          sel,
  input  bus_req_t                      req,
  input  tbl_row_t                      lookup_addr,
  output bus_rsp_t                      rsp,
  output bus_word_t [TBL_NUM_COLS-1:0]  lookup_row
);

  tbl_ofs_t  ofs;
  tbl_row_t  cmd_row;
  logic      wr_en;
  logic      rd_en;
  logic      row_ok;
  bus_word_t rd_data;

  bus_word_t [TBL_NUM_COLS-1:0] staging;
  bus_word_t [TBL_NUM_COLS-1:0] rows [TBL_NUM_ROWS];

  assign ofs     = req.addr[5:2];
  assign cmd_row = req.data[3:0];
  assign wr_en   = sel && !req.rnw;
  assign rd_en   = sel && req.rnw;
  assign row_ok  = cmd_row < TBL_NUM_ROWS;

  // Commands act at the strobe edge ahead of the ack
  always_ff @(posedge Bus2IP_Clk) begin
    if (!S_AXI_ARESETN) begin
      staging <= '0;
      for (int r = 0; r < TBL_NUM_ROWS; r++) begin
        rows[r] <= '0;
      end
    end else if (wr_en) begin
      for (int c = 0; c < TBL_NUM_COLS; c++) begin
        if (ofs == c) begin
          staging[c] <= be_merge(staging[c], req.data, req.be);
        end
      end
      if (ofs == TBL_CMD_WRITE_OFS && row_ok) begin
        rows[cmd_row] <= staging;
      end
      if (ofs == TBL_CMD_READ_OFS && row_ok) begin
        staging <= rows[cmd_row];
      end
    end
  end

  // Reserved offsets and the command offsets read as zero
  always_comb begin
    rd_data = '0;
    for (int c = 0; c < TBL_NUM_COLS; c++) begin
      if (ofs == c) begin
        rd_data = staging[c];
      end
    end
  end

  always_ff @(posedge Bus2IP_Clk) begin
    if (!S_AXI_ARESETN) begin
      rsp <= '0;
    end else begin
      rsp.data   <= rd_data;
      rsp.rd_ack <= rd_en;
      rsp.wr_ack <= wr_en;
      rsp.error  <= 1'b0;
    end
  end

  // Datapath lookup with one cycle of latency
  always_ff @(posedge Bus2IP_Clk) begin
    if (lookup_addr < TBL_NUM_ROWS) begin
      lookup_row <= rows[lookup_addr];
    end else begin
      lookup_row <= '0;
    end
  end

endmodule

// ==== filelist.f ====
design/opl_bus_pkg.sv
design/opl_router_pkg.sv
design/opl_bus_decode.sv
design/opl_reg_bank.sv
design/opl_stat_counters.sv
design/opl_table_regs.sv
design/opl_ctrl_top.sv
tests/opl_ctrl_tb.sv

// ==== tests/opl_ctrl_tb.sv ====
/* Testbench for the output port lookup control block, which checks random
   register, counter and table traffic against a reference model */

`timescale 1ns/1ps

module opl_ctrl_tb
  import opl_bus_pkg::*;
  import opl_router_pkg::*;
();

  localparam int CLK_PERIOD        = 40;
  localparam int NUM_ITER          = 40;
  localparam int EVENT_CYCLES      = 300;
  localparam int NUM_TABLES        = 3;
  localparam int TBL_DEPTH         = 16;
  // Strobe, two cycles of latency and some margin
  localparam int ACCESS_CYCLES     = 6;
  localparam int ACCESSES_PER_ITER = 50;
  localparam int WATCHDOG_NS =
    ((NUM_ITER * ACCESSES_PER_ITER + 200) * ACCESS_CYCLES + 3 * EVENT_CYCLES) * CLK_PERIOD;

  typedef bus_word_t [LPM_NUM_COLS-1:0] row_t;

  logic                            Bus2IP_Clk;
  logic                            S_AXI_ARESETN;
  logic [1:0]                      cs;
  bus_addr_t                       addr;
  logic                            rnw;
  bus_word_t                       wdata;
  bus_be_t                         be;
  bus_word_t                       rdata;
  logic                            rd_ack;
  logic                            wr_ack;
  logic                            error;
  stat_events_t                    events;
  mac_set_t                        macs;
  tbl_row_t                        lpm_addr;
  tbl_row_t                        arp_addr;
  tbl_row_t                        filter_addr;
  bus_word_t [LPM_NUM_COLS-1:0]    lpm_row;
  bus_word_t [ARP_NUM_COLS-1:0]    arp_row;
  bus_word_t [FILTER_NUM_COLS-1:0] filter_row;

  // Reference model
  int        seed;
  bus_word_t mac_m [REG_NUM_MAC_WORDS];
  bus_word_t cnt_m [NUM_STAT_CNTRS];
  row_t      tbl_m [NUM_TABLES][TBL_DEPTH];
  row_t      stage_m [NUM_TABLES];
  int        num_cols [NUM_TABLES] = '{LPM_NUM_COLS, ARP_NUM_COLS, FILTER_NUM_COLS};

  opl_ctrl_top i_opl_ctrl_top (
    .Bus2IP_Clk, .S_AXI_ARESETN,
    .Bus2IP_CS(cs), .Bus2IP_Addr(addr), .Bus2IP_RNW(rnw), .Bus2IP_Data(wdata),
    .Bus2IP_BE(be), .IP2Bus_Data(rdata), .IP2Bus_RdAck(rd_ack), .IP2Bus_WrAck(wr_ack),
    .IP2Bus_Error(error), .events, .macs,
    .lpm_lookup_addr(lpm_addr), .lpm_row,
    .arp_lookup_addr(arp_addr), .arp_row,
    .filter_lookup_addr(filter_addr), .filter_row
  );

  initial begin
    Bus2IP_Clk = 1'b0;
    forever #(CLK_PERIOD / 2) Bus2IP_Clk = ~Bus2IP_Clk;
  end

  task automatic stop_on_error(string msg);
    $display("%s", msg);
    $display("Testbench failed");
    $fatal(1);
  endtask

  initial begin
    #(WATCHDOG_NS);
    stop_on_error($sformatf("Watchdog expired after %0d ns, the test did not finish",
                            WATCHDOG_NS));
  end

  task automatic check_word(string name, bus_word_t got, bus_word_t exp);
    if (got !== exp) begin
      stop_on_error($sformatf("** Error: %s is 0x%h, expected 0x%h", name, got, exp));
    end
  endtask

  task automatic check_mac(string name, mac_addr_t got, mac_addr_t exp);
    if (got !== exp) begin
      stop_on_error($sformatf("** Error: %s is 0x%h, expected 0x%h", name, got, exp));
    end
  endtask

  task automatic check_flag(string name, logic got, logic exp);
    if (got !== exp) begin
      stop_on_error($sformatf("** Error: %s is 0x%h, expected 0x%h", name, got, exp));
    end
  endtask

  task automatic check_row(string name, row_t got, row_t exp);
    if (got !== exp) begin
      stop_on_error($sformatf("** Error: %s is 0x%h, expected 0x%h", name, got, exp));
    end
  endtask

  function automatic bus_word_t next_random();
    return $random(seed);
  endfunction

  function automatic int rand_below(int n);
    return $unsigned($random(seed)) % n;
  endfunction

  function automatic bus_word_t merge_bytes(bus_word_t old_w, bus_word_t new_w, bus_be_t en);
    bus_word_t w;
    w = old_w;
    for (int b = 0; b < 4; b++) begin
      if (en[b]) begin
        w[8*b +: 8] = new_w[8*b +: 8];
      end
    end
    return w;
  endfunction

  function automatic bus_addr_t reg_addr(int idx);
    return idx * 4;
  endfunction

  // Window number in bits 31:6 and word offset in bits 5:2
  function automatic bus_addr_t table_addr(int win, int ofs);
    return win * 64 + ofs * 4;
  endfunction

  function automatic mac_addr_t model_mac(int p);
    return {mac_m[2*p+1][15:0], mac_m[2*p]};
  endfunction

  // One access that is called and returns on a falling edge
  task automatic bus_access(input logic bar0, input bus_addr_t a, input logic read,
                            input bus_word_t d, input bus_be_t en, input logic exp_err,
                            output bus_word_t got);
    int waited;
    cs    = bar0 ? 2'b10 : 2'b01;
    addr  = a;
    rnw   = read;
    wdata = d;
    be    = en;
    @(negedge Bus2IP_Clk);
    cs     = 2'b00;
    waited = 0;
    while (!(rd_ack || wr_ack)) begin
      if (waited == 4) begin
        stop_on_error($sformatf("No ack within 4 cycles for the access to 0x%h", a));
      end
      @(negedge Bus2IP_Clk);
      waited++;
    end
    if (waited != 1) begin
      stop_on_error($sformatf("Ack for the access to 0x%h came %0d cycles after the strobe",
                              a, waited + 1));
    end
    check_flag("IP2Bus_RdAck", rd_ack, read);
    check_flag("IP2Bus_WrAck", wr_ack, !read);
    check_flag("IP2Bus_Error", error, exp_err);
    got = rdata;
  endtask

  task automatic write_word(logic bar0, bus_addr_t a, bus_word_t d, bus_be_t en);
    bus_word_t ignored;
    bus_access(bar0, a, 1'b0, d, en, 1'b0, ignored);
  endtask

  task automatic read_word(input logic bar0, input bus_addr_t a, output bus_word_t got);
    bus_access(bar0, a, 1'b1, '0, '0, 1'b0, got);
  endtask

  task automatic compare_counters();
    bus_word_t got;
    for (int i = 0; i < NUM_STAT_CNTRS; i++) begin
      read_word(1'b1, reg_addr(REG_CNTR_BASE_IDX + i), got);
      check_word($sformatf("counter %0d", i), got, cnt_m[i]);
    end
  endtask

  task automatic compare_macs();
    bus_word_t got;
    check_mac("macs.mac_0", macs.mac_0, model_mac(0));
    check_mac("macs.mac_1", macs.mac_1, model_mac(1));
    check_mac("macs.mac_2", macs.mac_2, model_mac(2));
    check_mac("macs.mac_3", macs.mac_3, model_mac(3));
    for (int m = 0; m < REG_NUM_MAC_WORDS; m++) begin
      read_word(1'b1, reg_addr(REG_MAC_BASE_IDX + m), got);
      check_word($sformatf("MAC word %0d", m), got, mac_m[m]);
    end
  endtask

  // Random pulses where the top bit is the from_cpu counter
  task automatic run_events(int cycles, logic counting);
    logic [NUM_STAT_CNTRS-1:0] ev_bits;
    bus_word_t                 r;
    for (int n = 0; n < cycles; n++) begin
      r       = next_random();
      ev_bits = r[NUM_STAT_CNTRS-1:0];
      events  = ev_bits;
      for (int i = 0; i < NUM_STAT_CNTRS; i++) begin
        if (counting && ev_bits[NUM_STAT_CNTRS-1-i]) begin
          cnt_m[i] = cnt_m[i] + 1;
        end
      end
      @(negedge Bus2IP_Clk);
    end
    events = '0;
  endtask

  task automatic fill_staging(int t);
    bus_word_t d;
    bus_word_t r;
    for (int c = 0; c < num_cols[t]; c++) begin
      d = next_random();
      r = next_random();
      write_word(1'b0, table_addr(t, c), d, r[3:0]);
      stage_m[t][c] = merge_bytes(stage_m[t][c], d, r[3:0]);
    end
  endtask

  task automatic compare_staging(int t);
    bus_word_t got;
    for (int c = 0; c < num_cols[t]; c++) begin
      read_word(1'b0, table_addr(t, c), got);
      check_word($sformatf("table %0d staging %0d", t, c), got, stage_m[t][c]);
    end
  endtask

  // Row shows up on the port one cycle after the address
  task automatic compare_lookup(int t, int row);
    row_t got_row;
    case (t)
      TBL_WIN_LPM: lpm_addr = tbl_row_t'(row);
      TBL_WIN_ARP: arp_addr = tbl_row_t'(row);
      default:     filter_addr = tbl_row_t'(row);
    endcase
    @(negedge Bus2IP_Clk);
    got_row = '0;
    case (t)
      TBL_WIN_LPM: got_row = lpm_row;
      TBL_WIN_ARP: got_row[ARP_NUM_COLS-1:0] = arp_row;
      default:     got_row[FILTER_NUM_COLS-1:0] = filter_row;
    endcase
    check_row($sformatf("table %0d lookup row %0d", t, row), got_row, tbl_m[t][row]);
  endtask

  initial begin
    bus_word_t got;
    bus_word_t d;
    bus_word_t r;
    int        idx;
    int        row;
    seed          = 4;
    S_AXI_ARESETN = 1'b0;
    cs            = 2'b00;
    addr          = '0;
    rnw           = 1'b1;
    wdata         = '0;
    be            = '0;
    events        = '0;
    lpm_addr      = '0;
    arp_addr      = '0;
    filter_addr   = '0;
    foreach (mac_m[m]) begin
      mac_m[m] = '0;
    end
    foreach (cnt_m[i]) begin
      cnt_m[i] = '0;
    end
    foreach (stage_m[t]) begin
      stage_m[t] = '0;
    end
    foreach (tbl_m[t, n]) begin
      tbl_m[t][n] = '0;
    end
    repeat (3) @(posedge Bus2IP_Clk);
    @(negedge Bus2IP_Clk);
    S_AXI_ARESETN = 1'b1;

    // Reset state
    check_flag("IP2Bus_RdAck", rd_ack, 1'b0);
    check_flag("IP2Bus_WrAck", wr_ack, 1'b0);
    check_flag("IP2Bus_Error", error, 1'b0);
    compare_macs();
    compare_counters();

    // MAC words with byte enables while counter words ignore writes
    for (int n = 0; n < NUM_ITER; n++) begin
      idx = rand_below(REG_NUM_MAC_WORDS);
      d   = next_random();
      r   = next_random();
      write_word(1'b1, reg_addr(REG_MAC_BASE_IDX + idx), d, r[3:0]);
      mac_m[idx] = merge_bytes(mac_m[idx], d, r[3:0]);
      if (idx % 2 == 1) begin
        mac_m[idx][31:16] = '0;
      end
      idx = rand_below(NUM_STAT_CNTRS);
      write_word(1'b1, reg_addr(REG_CNTR_BASE_IDX + idx), next_random(), 4'hf);
      if (n % 10 == 9) begin
        compare_macs();
      end
    end
    compare_counters();

    // Counting, clear level, counting again
    run_events(EVENT_CYCLES, 1'b1);
    compare_counters();
    write_word(1'b1, reg_addr(REG_CTRL_IDX), 32'h1, 4'h1);
    foreach (cnt_m[i]) begin
      cnt_m[i] = '0;
    end
    read_word(1'b1, reg_addr(REG_CTRL_IDX), got);
    check_word("rst_cntrs register", got, 32'h1);
    run_events(EVENT_CYCLES / 10, 1'b0);
    compare_counters();
    write_word(1'b1, reg_addr(REG_CTRL_IDX), 32'h0, 4'h1);
    compare_counters();
    run_events(EVENT_CYCLES, 1'b1);
    compare_counters();

    // Tables through staging and row commands
    for (int t = 0; t < NUM_TABLES; t++) begin
      for (int n = 0; n < NUM_ITER; n++) begin
        row = rand_below(TBL_DEPTH);
        fill_staging(t);
        write_word(1'b0, table_addr(t, TBL_CMD_WRITE_OFS), row, 4'hf);
        tbl_m[t][row] = stage_m[t];
        compare_lookup(t, row);
        fill_staging(t);
        write_word(1'b0, table_addr(t, TBL_CMD_READ_OFS), row, 4'hf);
        stage_m[t] = tbl_m[t][row];
        compare_staging(t);
      end
      for (int n = 0; n < TBL_DEPTH; n++) begin
        compare_lookup(t, n);
      end
    end

    // Unmapped accesses answer with an error and zero data
    for (int n = 0; n < NUM_ITER; n++) begin
      idx = BAR0_NUM_REGS + rand_below(32 - BAR0_NUM_REGS);
      bus_access(1'b1, reg_addr(idx), 1'b1, '0, '0, 1'b1, got);
      check_word("unmapped BAR0 read data", got, '0);
      bus_access(1'b1, reg_addr(idx), 1'b0, next_random(), 4'hf, 1'b1, got);
      r = next_random();
      if (r[31:6] <= TBL_WIN_FILTER) begin
        r[31:6] = r[31:6] + 26'd3;
      end
      bus_access(1'b0, r, 1'b1, '0, '0, 1'b1, got);
      check_word("unmapped BAR1 read data", got, '0);
      bus_access(1'b0, r, 1'b0, next_random(), 4'hf, 1'b1, got);
    end
    for (int t = 0; t < NUM_TABLES; t++) begin
      for (int ofs = num_cols[t]; ofs < 16; ofs++) begin
        read_word(1'b0, table_addr(t, ofs), got);
        check_word($sformatf("table %0d reserved offset %0d", t, ofs), got, '0);
      end
    end
    compare_macs();

    $display("Testbench passed");
    $finish;
  end

endmodule
